// ==== cpuIsaPkg.sv ====
//////////////////////////////////////////////////
// Instruction set of the 16-bit core
// Opcodes, branch conditions, flag bits, word formats
//////////////////////////////////////////////////
package cpuIsaPkg;

  // Opcodes, bits [15:12]
  localparam logic [3:0] opAdd = 4'd0;
  localparam logic [3:0] opSub = 4'd1;
  localparam logic [3:0] opXor = 4'd2;
  localparam logic [3:0] opSll = 4'd4;
  localparam logic [3:0] opSra = 4'd5;
  localparam logic [3:0] opLw  = 4'd8;
  localparam logic [3:0] opSw  = 4'd9;
  localparam logic [3:0] opLlb = 4'd10;
  localparam logic [3:0] opLhb = 4'd11;
  localparam logic [3:0] opB   = 4'd12;
  localparam logic [3:0] opBr  = 4'd13;
  localparam logic [3:0] opHlt = 4'd15;

  // Branch conditions, bits [11:9] of B and BR
  localparam logic [2:0] condNe = 3'd0;
  localparam logic [2:0] condEq = 3'd1;
  localparam logic [2:0] condGt = 3'd2;
  localparam logic [2:0] condLt = 3'd3;
  localparam logic [2:0] condGe = 3'd4;
  localparam logic [2:0] condLe = 3'd5;
  localparam logic [2:0] condOv = 3'd6;
  localparam logic [2:0] condAl = 3'd7;

  // Bit positions in the flag word
  localparam int flagZ = 2;
  localparam int flagV = 1;
  localparam int flagN = 0;

  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rd;
    logic [3:0] rs;   // High immediate nibble for LLB/LHB
    logic [3:0] rt;   // Shift amount or word offset for immediates
  } regFields;

  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] cond;
    logic [8:0] offset;   // Signed, in words
  } branchFields;

  typedef union packed {
    regFields    regForm;
    branchFields branchForm;
  } instrWord;

endpackage

// ==== cpuPipePkg.sv ====
//////////////////////////////////////////////////
// Pipeline widths and forwarding mux codes
//////////////////////////////////////////////////
package cpuPipePkg;

  localparam int dataWidth    = 16;   // Registers, addresses, memory words
  localparam int regAddrWidth = 4;

  // Operand source in execute
  localparam logic [1:0] fwdReg = 2'd0;   // Value read in decode
  localparam logic [1:0] fwdMem = 2'd1;   // Result in memory stage
  localparam logic [1:0] fwdWb  = 2'd2;   // Result in write-back

endpackage

// ==== controlUnit.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Opcode decode into decode-stage control bits
//////////////////////////////////////////////////
module controlUnit import cpuIsaPkg::*; (
  input  logic [3:0] opcode,
  output logic       regWrite,
  output logic       memToReg,
  output logic       memWrite,
  output logic       aluSrc,      // Immediate on ALU input B
  output logic       dstRegSel,   // Rd field is a destination, 0 for store data
  output logic       branch,
  output logic [2:0] flagWrite,   // Per-flag update mask
  output logic       halt
);

  always_comb begin
    regWrite  = 1'b0;
    memToReg  = 1'b0;
    memWrite  = 1'b0;
    aluSrc    = 1'b1;   // Most forms carry an immediate
    dstRegSel = 1'b1;
    branch    = 1'b0;
    flagWrite = 3'b000;
    halt      = 1'b0;
    case (opcode)
      opAdd, opSub: begin
        regWrite  = 1'b1;
        aluSrc    = 1'b0;
        flagWrite = 3'b111;   // Z, V and N
      end
      opXor: begin
        regWrite         = 1'b1;
        aluSrc           = 1'b0;
        flagWrite[flagZ] = 1'b1;
      end
      opSll, opSra: begin
        regWrite         = 1'b1;
        flagWrite[flagZ] = 1'b1;
      end
      opLw: begin
        regWrite = 1'b1;
        memToReg = 1'b1;
      end
      opSw: begin
        memWrite  = 1'b1;
        dstRegSel = 1'b0;   // Rd field holds the data register
      end
      opLlb, opLhb: regWrite = 1'b1;
      opB, opBr:    branch = 1'b1;
      opHlt:        halt = 1'b1;
      default: ;            // Unused opcodes act as no-ops
    endcase
  end

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Sixteen-entry register file, two reads, one write
// Same-cycle write is visible on the read ports
//////////////////////////////////////////////////
module registerFile import cpuPipePkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [regAddrWidth-1:0] srcReg1,
  input  logic [regAddrWidth-1:0] srcReg2,
  input  logic [regAddrWidth-1:0] dstReg,
  input  logic                    writeReg,
  input  logic [dataWidth-1:0]    dstData,
  output logic [dataWidth-1:0]    srcData1,
  output logic [dataWidth-1:0]    srcData2
);

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (writeReg && dstReg != '0) begin   // R0 never written
      regs[dstReg] <= dstData;
    end
  end

  // R0 reads zero, then write-back bypass
  assign srcData1 = (srcReg1 == '0) ? '0 :
                    (writeReg && dstReg == srcReg1) ? dstData : regs[srcReg1];
  assign srcData2 = (srcReg2 == '0) ? '0 :
                    (writeReg && dstReg == srcReg2) ? dstData : regs[srcReg2];

endmodule

// ==== aluCompute.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Execute-stage ALU with Z, V and N flag outputs
//////////////////////////////////////////////////
module aluCompute import cpuIsaPkg::*, cpuPipePkg::*; (
  input  logic [3:0]           opcode,
  input  logic [dataWidth-1:0] inputA,
  input  logic [dataWidth-1:0] inputB,
  output logic [dataWidth-1:0] aluOut,
  output logic [2:0]           aluFlags
);

  localparam int msb = dataWidth - 1;

  logic [dataWidth-1:0] sum;
  logic [dataWidth-1:0] diff;
  logic                 addOvf;
  logic                 subOvf;

  assign sum  = inputA + inputB;   // Also the LW/SW address
  assign diff = inputA - inputB;

  // Like signs in, other sign out
  assign addOvf = (inputA[msb] == inputB[msb]) && (sum[msb] != inputA[msb]);
  // Unlike signs in, result takes the subtrahend sign
  assign subOvf = (inputA[msb] != inputB[msb]) && (diff[msb] != inputA[msb]);

  always_comb begin
    case (opcode)
      opAdd:   aluOut = sum;
      opSub:   aluOut = diff;
      opXor:   aluOut = inputA ^ inputB;
      opSll:   aluOut = inputA << inputB[3:0];
      opSra:   aluOut = $signed(inputA) >>> inputB[3:0];
      opLlb:   aluOut = {inputA[msb:8], inputB[7:0]};   // Keep high byte
      opLhb:   aluOut = {inputB[7:0], inputA[7:0]};     // Keep low byte
      default: aluOut = sum;
    endcase
  end

  always_comb begin
    aluFlags        = '0;
    aluFlags[flagZ] = (aluOut == '0);
    aluFlags[flagN] = aluOut[msb];
    aluFlags[flagV] = (opcode == opSub) ? subOvf : addOvf;   // Masked off unless ADD/SUB
  end

endmodule

// ==== branchResolve.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Flag register and decode-stage branch decision
//////////////////////////////////////////////////
module branchResolve import cpuIsaPkg::*, cpuPipePkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flagWrite,
  input  logic [2:0]           flagMask,
  input  logic [2:0]           aluFlags,
  input  logic                 branch,
  input  logic                 isRegBranch,
  input  logic [2:0]           cond,
  input  logic [8:0]           offset,
  input  logic [dataWidth-1:0] pcPlus2,
  input  logic [dataWidth-1:0] regTarget,
  output logic                 branchTaken,
  output logic [dataWidth-1:0] branchTarget
);

  logic [2:0] flags;
  logic       condPass;

  // Only the masked flags move
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (flagWrite) begin
      flags <= (flags & ~flagMask) | (aluFlags & flagMask);
    end
  end

  always_comb begin
    case (cond)
      condNe:  condPass = !flags[flagZ];
      condEq:  condPass = flags[flagZ];
      condGt:  condPass = !flags[flagZ] && !flags[flagN];
      condLt:  condPass = flags[flagN];
      condGe:  condPass = flags[flagZ] || !flags[flagN];
      condLe:  condPass = flags[flagZ] || flags[flagN];
      condOv:  condPass = flags[flagV];
      condAl:  condPass = 1'b1;
      default: condPass = 1'b0;
    endcase
  end

  assign branchTaken  = branch && condPass;
  // BR jumps to the register, B to PC+2 plus word offset
  assign branchTarget = isRegBranch ? regTarget :
                        pcPlus2 + {{(dataWidth-10){offset[8]}}, offset, 1'b0};

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Forwarding selects, stalls and squashes
//////////////////////////////////////////////////
module hazardUnit import cpuPipePkg::*; (
  input  logic [regAddrWidth-1:0] srcRegAD,
  input  logic [regAddrWidth-1:0] srcRegBD,
  input  logic [regAddrWidth-1:0] srcRegAE,
  input  logic [regAddrWidth-1:0] srcRegBE,
  input  logic                    regWriteE,
  input  logic [regAddrWidth-1:0] dstRegE,
  input  logic                    regWriteM,
  input  logic [regAddrWidth-1:0] dstRegM,
  input  logic                    regWriteW,
  input  logic [regAddrWidth-1:0] dstRegW,
  input  logic                    memToRegE,
  input  logic                    flagWriteE,
  input  logic                    branchD,
  input  logic                    branchTaken,
  input  logic                    haltD,        // HLT decoded now or earlier
  output logic                    stallF,
  output logic                    stallD,
  output logic                    flushD,
  output logic                    flushE,
  output logic [1:0]              fwdASel,
  output logic [1:0]              fwdBSel
);

  logic loadUse;
  logic flagStall;
  logic brRegStall;
  logic stall;

  // Youngest producer wins, R0 never forwarded
  function automatic logic [1:0] pickFwd(input logic [regAddrWidth-1:0] src);
    if (src == '0) return fwdReg;
    if (regWriteM && dstRegM == src) return fwdMem;
    if (regWriteW && dstRegW == src) return fwdWb;
    return fwdReg;
  endfunction

  always_comb begin
    fwdASel = pickFwd(srcRegAE);
    fwdBSel = pickFwd(srcRegBE);
  end

  assign loadUse    = memToRegE && regWriteE && dstRegE != '0 &&
                      (dstRegE == srcRegAD || dstRegE == srcRegBD);
  assign flagStall  = branchD && flagWriteE;   // Flags not settled yet
  assign brRegStall = branchD && regWriteE && srcRegAD != '0 && dstRegE == srcRegAD;
  assign stall      = loadUse || flagStall || brRegStall;

  assign stallF = stall || haltD;    // Fetch freezes for good on HLT
  assign stallD = stall;
  assign flushE = stall;             // Bubble into execute
  assign flushD = !stall && (branchTaken || haltD);

endmodule

// ==== memory.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Single-cycle instruction and data memories
// Program is written by word address during reset
//////////////////////////////////////////////////
module memory import cpuIsaPkg::*, cpuPipePkg::*; #(
  parameter int memWords = 256
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 progWrite,
  input  logic [dataWidth-1:0] progAddr,
  input  logic [dataWidth-1:0] progData,
  input  logic [dataWidth-1:0] iAddr,      // Byte address
  input  logic [dataWidth-1:0] dAddr,      // Byte address
  input  logic                 dWriteEn,
  input  logic [dataWidth-1:0] dataIn,
  output instrWord             instrOut,
  output logic [dataWidth-1:0] dataOut
);

  localparam int idxWidth = $clog2(memWords);

  instrWord             instrMem [memWords];
  logic [dataWidth-1:0] dataMem  [memWords];

  always_ff @(posedge clk) begin
    if (progWrite) begin
      instrMem[progAddr[idxWidth-1:0]] <= progData;
    end
  end

  assign instrOut = instrMem[iAddr[idxWidth:1]];   // Bit 0 dropped

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < memWords; i++) begin
        dataMem[i] <= '0;
      end
    end else if (dWriteEn) begin
      dataMem[dAddr[idxWidth:1]] <= dataIn;
    end
  end

  assign dataOut = dataMem[dAddr[idxWidth:1]];

endmodule

// ==== cpu.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Five-stage pipelined 16-bit core, top level
// Load the program through progWrite while in reset
//////////////////////////////////////////////////
module cpu import cpuIsaPkg::*, cpuPipePkg::*; #(
  parameter int memWords = 256
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    progWrite,
  input  logic [dataWidth-1:0]    progAddr,
  input  logic [dataWidth-1:0]    progData,
  output logic                    hlt,
  output logic [dataWidth-1:0]    pcOut,
  output logic                    commitValid,
  output logic [regAddrWidth-1:0] commitReg,
  output logic [dataWidth-1:0]    commitData
);

  // Hazard controls
  logic       stallF, stallD, flushD, flushE;
  logic [1:0] fwdASel, fwdBSel;

  // Fetch
  logic [dataWidth-1:0] pc, pcPlus2F, branchTarget;
  logic                 branchTaken;
  instrWord             instrF;

  // Decode
  logic                    validD, fetchHalted, haltFetch;
  instrWord                instrD;
  logic [3:0]              opcodeD;
  logic                    regWriteD, memToRegD, memWriteD, aluSrcD;
  logic                    dstRegSelD, branchD, haltD;
  logic [2:0]              flagMaskD;
  logic [regAddrWidth-1:0] srcRegAD, srcRegBD, dstRegD;
  logic [dataWidth-1:0]    pcPlus2D, immD, srcData1D, srcData2D, regTargetD;

  // Execute
  logic                    validE, regWriteE, memToRegE, memWriteE, aluSrcE, haltE;
  logic                    flagWriteE;
  logic [3:0]              opcodeE;
  logic [2:0]              flagMaskE, aluFlagsE;
  logic [regAddrWidth-1:0] srcRegAE, srcRegBE, dstRegE;
  logic [dataWidth-1:0]    immE, srcData1E, srcData2E;
  logic [dataWidth-1:0]    fwdAE, fwdBE, inputBE, aluOutE;

  // Memory and write-back
  logic                    validM, regWriteM, memToRegM, memWriteM, haltM;
  logic [regAddrWidth-1:0] dstRegM, dstRegW;
  logic [dataWidth-1:0]    aluOutM, storeDataM, dataOutM, resultM, resultW;
  logic                    validW, regWriteW, haltW, hltSeen;

  //////////////////// F ////////////////////////////
  assign pcPlus2F = pc + dataWidth'(2);
  assign pcOut    = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!stallF) begin
      pc <= branchTaken ? branchTarget : pcPlus2F;   // Redirect from decode
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flushD) begin
      validD <= 1'b0;
      instrD <= '0;          // Reads as ADD R0, nothing hazards on it
    end else if (!stallD) begin
      validD   <= 1'b1;
      instrD   <= instrF;
      pcPlus2D <= pcPlus2F;
    end
  end

  //////////////////// D ////////////////////////////
  assign opcodeD = instrD.regForm.opcode;
  assign dstRegD = instrD.regForm.rd;   // Every writer names rd

  controlUnit ctrl (
    .opcode(opcodeD), .regWrite(regWriteD), .memToReg(memToRegD),
    .memWrite(memWriteD), .aluSrc(aluSrcD), .dstRegSel(dstRegSelD),
    .branch(branchD), .flagWrite(flagMaskD), .halt(haltD)
  );

  // Operand A, LLB/LHB merge into the old rd value
  always_comb begin
    case (opcodeD)
      opLlb, opLhb: srcRegAD = instrD.regForm.rd;
      opB, opHlt:   srcRegAD = '0;   // Nothing read
      default:      srcRegAD = instrD.regForm.rs;
    endcase
  end

  // Operand B, R0 when the field is an immediate
  assign srcRegBD = !dstRegSelD ? instrD.regForm.rd :
                    aluSrcD     ? '0 : instrD.regForm.rt;

  always_comb begin
    case (opcodeD)
      opLlb, opLhb: immD = {{(dataWidth-8){instrD.regForm.rs[3]}},
                            instrD.regForm.rs, instrD.regForm.rt};
      opLw, opSw:   immD = {{(dataWidth-5){1'b0}}, instrD.regForm.rt, 1'b0};   // Words to bytes
      default:      immD = {{(dataWidth-4){1'b0}}, instrD.regForm.rt};         // Shift amount
    endcase
  end

  registerFile regs (
    .clk(clk), .reset(reset), .srcReg1(srcRegAD), .srcReg2(srcRegBD),
    .dstReg(dstRegW), .writeReg(commitValid), .dstData(resultW),
    .srcData1(srcData1D), .srcData2(srcData2D)
  );

  // BR target from memory stage, write-back comes through the bypass
  assign regTargetD = (regWriteM && srcRegAD != '0 && dstRegM == srcRegAD) ?
                      resultM : srcData1D;

  branchResolve branchUnit (
    .clk(clk), .reset(reset), .flagWrite(flagWriteE), .flagMask(flagMaskE),
    .aluFlags(aluFlagsE), .branch(branchD && validD), .isRegBranch(opcodeD == opBr),
    .cond(instrD.branchForm.cond), .offset(instrD.branchForm.offset),
    .pcPlus2(pcPlus2D), .regTarget(regTargetD),
    .branchTaken(branchTaken), .branchTarget(branchTarget)
  );

  // Fetch stays frozen once HLT is seen
  assign haltFetch = fetchHalted || (haltD && validD);

  always_ff @(posedge clk) begin
    if (reset) begin
      fetchHalted <= 1'b0;
    end else if (haltD && validD) begin
      fetchHalted <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flushE || !validD) begin
      validE    <= 1'b0;
      regWriteE <= 1'b0;
      memToRegE <= 1'b0;
      memWriteE <= 1'b0;
      flagMaskE <= '0;
      haltE     <= 1'b0;
    end else begin
      validE    <= 1'b1;
      regWriteE <= regWriteD;
      memToRegE <= memToRegD;
      memWriteE <= memWriteD;
      flagMaskE <= flagMaskD;
      haltE     <= haltD;
      aluSrcE   <= aluSrcD;
      opcodeE   <= opcodeD;
      srcRegAE  <= srcRegAD;
      srcRegBE  <= srcRegBD;
      dstRegE   <= dstRegD;
      immE      <= immD;
      srcData1E <= srcData1D;
      srcData2E <= srcData2D;
    end
  end

  //////////////////// E ////////////////////////////
  assign fwdAE = (fwdASel == fwdMem) ? resultM :
                 (fwdASel == fwdWb)  ? resultW : srcData1E;
  assign fwdBE = (fwdBSel == fwdMem) ? resultM :
                 (fwdBSel == fwdWb)  ? resultW : srcData2E;
  assign inputBE    = aluSrcE ? immE : fwdBE;
  assign flagWriteE = |flagMaskE;   // Bubbles carry an empty mask

  aluCompute alu (
    .opcode(opcodeE), .inputA(fwdAE), .inputB(inputBE),
    .aluOut(aluOutE), .aluFlags(aluFlagsE)
  );

  hazardUnit hazards (
    .srcRegAD(srcRegAD), .srcRegBD(srcRegBD), .srcRegAE(srcRegAE), .srcRegBE(srcRegBE),
    .regWriteE(regWriteE), .dstRegE(dstRegE), .regWriteM(regWriteM), .dstRegM(dstRegM),
    .regWriteW(regWriteW), .dstRegW(dstRegW), .memToRegE(memToRegE),
    .flagWriteE(flagWriteE), .branchD(branchD && validD), .branchTaken(branchTaken),
    .haltD(haltFetch), .stallF(stallF), .stallD(stallD), .flushD(flushD),
    .flushE(flushE), .fwdASel(fwdASel), .fwdBSel(fwdBSel)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      validM    <= 1'b0;
      regWriteM <= 1'b0;
      memToRegM <= 1'b0;
      memWriteM <= 1'b0;
      haltM     <= 1'b0;
    end else begin
      validM     <= validE;
      regWriteM  <= regWriteE;
      memToRegM  <= memToRegE;
      memWriteM  <= memWriteE;
      haltM      <= haltE;
      dstRegM    <= dstRegE;
      aluOutM    <= aluOutE;
      storeDataM <= fwdBE;   // SW data, already forwarded
    end
  end

  //////////////////// M ////////////////////////////
  memory #(.memWords(memWords)) mem (
    .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .iAddr(pc), .dAddr(aluOutM), .dWriteEn(memWriteM),
    .dataIn(storeDataM), .instrOut(instrF), .dataOut(dataOutM)
  );

  assign resultM = memToRegM ? dataOutM : aluOutM;

  always_ff @(posedge clk) begin
    if (reset) begin
      validW    <= 1'b0;
      regWriteW <= 1'b0;
      haltW     <= 1'b0;
    end else begin
      validW    <= validM;
      regWriteW <= regWriteM;
      haltW     <= haltM;
      dstRegW   <= dstRegM;
      resultW   <= resultM;
    end
  end

  //////////////////// W ////////////////////////////
  assign commitValid = validW && regWriteW;
  assign commitReg   = dstRegW;
  assign commitData  = resultW;

  // Sticky once HLT retires
  always_ff @(posedge clk) begin
    if (reset) begin
      hltSeen <= 1'b0;
    end else if (validW && haltW) begin
      hltSeen <= 1'b1;
    end
  end

  assign hlt = hltSeen || (validW && haltW);

endmodule

// ==== cpuTb.sv ====
`timescale 1ns/1ps
//////////////////////////////////////////////////
// Testbench for the pipelined core: loads a program
// during reset, then checks every commit and the halt
//////////////////////////////////////////////////
module cpuTb import cpuIsaPkg::*, cpuPipePkg::*; ();

  logic                    clk;
  logic                    reset;
  logic                    progWrite;
  logic [dataWidth-1:0]    progAddr;
  logic [dataWidth-1:0]    progData;
  logic                    hlt;
  logic [dataWidth-1:0]    pcOut;
  logic                    commitValid;
  logic [regAddrWidth-1:0] commitReg;
  logic [dataWidth-1:0]    commitData;

  // Program table, one row per word, word address = row index
  string                   rowName[$];
  instrWord                rowWord[$];
  bit                      rowCommits[$];   // 0 for stores, branches, skipped rows
  logic [regAddrWidth-1:0] rowReg[$];
  logic [dataWidth-1:0]    rowData[$];

  int                      cycles;
  int                      cycleLimit;
  int                      rowIdx;
  bit                      halted;
  logic [dataWidth-1:0]    haltPc;

  cpu cpu_inst (
    .clk(clk), .reset(reset), .progWrite(progWrite), .progAddr(progAddr),
    .progData(progData), .hlt(hlt), .pcOut(pcOut), .commitValid(commitValid),
    .commitReg(commitReg), .commitData(commitData)
  );

  always #5 clk = ~clk;   // 10 ns period

  ////////////////// Encoders //////////////////////
  function automatic instrWord encReg(input logic [3:0] op, input logic [3:0] rd,
                                      input logic [3:0] rs, input logic [3:0] rt);
    instrWord w;
    w.regForm.opcode = op;
    w.regForm.rd     = rd;
    w.regForm.rs     = rs;
    w.regForm.rt     = rt;
    return w;
  endfunction

  // LLB/LHB, byte split over rs and rt
  function automatic instrWord encByte(input logic [3:0] op, input logic [3:0] rd,
                                       input logic [7:0] imm);
    return encReg(op, rd, imm[7:4], imm[3:0]);
  endfunction

  function automatic instrWord encBranch(input logic [2:0] cond, input logic [8:0] offset);
    instrWord w;
    w.branchForm.opcode = opB;
    w.branchForm.cond   = cond;
    w.branchForm.offset = offset;   // In words, from PC+2
    return w;
  endfunction

  function automatic instrWord encRegBranch(input logic [2:0] cond, input logic [3:0] rs);
    instrWord w;
    w                   = '0;
    w.branchForm.opcode = opBr;
    w.branchForm.cond   = cond;
    w.regForm.rs        = rs;   // Target register in bits 7:4
    return w;
  endfunction

  ////////////////// Checks ////////////////////////
  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkReg(input string testName, input logic [regAddrWidth-1:0] expected,
                          input logic [regAddrWidth-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected R%0d, actual R%0d", testName, expected, actual);
      abortRun("Commit went to the wrong register");
    end
  endtask

  task automatic checkData(input string testName, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: expected %h, actual %h", testName, expected, actual);
      abortRun("Wrong data value");
    end
  endtask

  // First row at or after from that writes a register
  function automatic int nextCommitRow(input int from);
    int i;
    i = from;
    while (i < rowWord.size() && !rowCommits[i]) begin
      i++;
    end
    return i;
  endfunction

  task automatic addRow(input string name, input instrWord word, input bit commits,
                        input logic [regAddrWidth-1:0] expReg,
                        input logic [dataWidth-1:0] expData);
    rowName.push_back(name);
    rowWord.push_back(word);
    rowCommits.push_back(commits);
    rowReg.push_back(expReg);
    rowData.push_back(expData);
  endtask

  ////////////////// Program ///////////////////////
  task automatic buildTable();
    // Constants, back-to-back LLB/LHB pairs
    addRow("llb r1",          encByte(opLlb, 4'd1, 8'h34), 1'b1, 4'd1, 16'h0034);
    addRow("lhb r1",          encByte(opLhb, 4'd1, 8'h12), 1'b1, 4'd1, 16'h1234);
    addRow("llb r2",          encByte(opLlb, 4'd2, 8'hf0), 1'b1, 4'd2, 16'h00f0);
    addRow("lhb r2",          encByte(opLhb, 4'd2, 8'hff), 1'b1, 4'd2, 16'hfff0);
    // ALU ops, operands one and two rows back
    addRow("add r3",          encReg(opAdd, 4'd3, 4'd1, 4'd2), 1'b1, 4'd3, 16'h1224);
    addRow("sub r4",          encReg(opSub, 4'd4, 4'd3, 4'd1), 1'b1, 4'd4, 16'hfff0);
    addRow("xor r5",          encReg(opXor, 4'd5, 4'd4, 4'd3), 1'b1, 4'd5, 16'hedd4);
    addRow("sll r6",          encReg(opSll, 4'd6, 4'd1, 4'd4), 1'b1, 4'd6, 16'h2340);
    addRow("sra r7",          encReg(opSra, 4'd7, 4'd4, 4'd2), 1'b1, 4'd7, 16'hfffc);
    addRow("add r0",          encReg(opAdd, 4'd0, 4'd1, 4'd1), 1'b1, 4'd0, 16'h2468);
    addRow("add r8 from r0",  encReg(opAdd, 4'd8, 4'd0, 4'd6), 1'b1, 4'd8, 16'h2340);
    // Store and load round trips, load-use stall
    addRow("sw r3",           encReg(opSw, 4'd3, 4'd0, 4'd4), 1'b0, 4'd0, 16'h0000);
    addRow("lw r9",           encReg(opLw, 4'd9, 4'd0, 4'd4), 1'b1, 4'd9, 16'h1224);
    addRow("add r10 load use", encReg(opAdd, 4'd10, 4'd9, 4'd1), 1'b1, 4'd10, 16'h2458);
    addRow("sw r10",          encReg(opSw, 4'd10, 4'd0, 4'd5), 1'b0, 4'd0, 16'h0000);
    addRow("lw r11",          encReg(opLw, 4'd11, 4'd0, 4'd5), 1'b1, 4'd11, 16'h2458);
    // Branches on Z, then N
    addRow("sub r12 zero",    encReg(opSub, 4'd12, 4'd1, 4'd1), 1'b1, 4'd12, 16'h0000);
    addRow("b eq taken",      encBranch(condEq, 9'd2), 1'b0, 4'd0, 16'h0000);
    addRow("skipped eq 1",    encByte(opLlb, 4'd13, 8'h11), 1'b0, 4'd0, 16'h0000);
    addRow("skipped eq 2",    encByte(opLlb, 4'd13, 8'h22), 1'b0, 4'd0, 16'h0000);
    addRow("b ne not taken",  encBranch(condNe, 9'd1), 1'b0, 4'd0, 16'h0000);
    addRow("llb r13",         encByte(opLlb, 4'd13, 8'h77), 1'b1, 4'd13, 16'h0077);
    addRow("add r14 neg",     encReg(opAdd, 4'd14, 4'd4, 4'd2), 1'b1, 4'd14, 16'hffe0);
    addRow("b lt taken",      encBranch(condLt, 9'd1), 1'b0, 4'd0, 16'h0000);
    addRow("skipped lt",      encByte(opLlb, 4'd13, 8'h55), 1'b0, 4'd0, 16'h0000);
    addRow("b gt not taken",  encBranch(condGt, 9'd1), 1'b0, 4'd0, 16'h0000);
    // Signed overflow
    addRow("llb r15",         encByte(opLlb, 4'd15, 8'hff), 1'b1, 4'd15, 16'h00ff);
    addRow("lhb r15",         encByte(opLhb, 4'd15, 8'h7f), 1'b1, 4'd15, 16'h7fff);
    addRow("add r13 ovf",     encReg(opAdd, 4'd13, 4'd15, 4'd15), 1'b1, 4'd13, 16'hfffe);
    addRow("b ov taken",      encBranch(condOv, 9'd1), 1'b0, 4'd0, 16'h0000);
    addRow("skipped ov",      encByte(opLlb, 4'd13, 8'h66), 1'b0, 4'd0, 16'h0000);
    // Register branch to word 35, over a HLT
    addRow("llb r12 target",  encByte(opLlb, 4'd12, 8'h46), 1'b1, 4'd12, 16'h0046);
    addRow("br always",       encRegBranch(condAl, 4'd12), 1'b0, 4'd0, 16'h0000);
    addRow("skipped br",      encByte(opLlb, 4'd13, 8'h99), 1'b0, 4'd0, 16'h0000);
    addRow("skipped hlt",     encReg(opHlt, 4'd0, 4'd0, 4'd0), 1'b0, 4'd0, 16'h0000);
    addRow("sra r7 target",   encReg(opSra, 4'd7, 4'd13, 4'd1), 1'b1, 4'd7, 16'hffff);
    addRow("hlt",             encReg(opHlt, 4'd0, 4'd0, 4'd0), 1'b0, 4'd0, 16'h0000);
  endtask

  ////////////////// Sequence //////////////////////
  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    progWrite = 1'b0;
    progAddr  = '0;
    progData  = '0;
    buildTable();
    cycleLimit = 4 * rowWord.size() + 30;

    // One word per clock while reset is high
    for (int i = 0; i < rowWord.size(); i++) begin
      @(posedge clk);
      progWrite <= 1'b1;
      progAddr  <= dataWidth'(i);
      progData  <= rowWord[i];
    end
    @(posedge clk);
    progWrite <= 1'b0;
    repeat (3) @(posedge clk);   // Plain reset cycles
    reset <= 1'b0;

    // Commits must follow the table in order
    cycles = 0;
    rowIdx = 0;
    halted = 1'b0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > cycleLimit) begin
        abortRun($sformatf("Timeout after %0d cycles, the processor never halted", cycles));
      end
      if (commitValid) begin
        rowIdx = nextCommitRow(rowIdx);
        if (rowIdx >= rowWord.size()) begin
          abortRun("Commit seen after the last expected row");
        end
        checkReg(rowName[rowIdx], rowReg[rowIdx], commitReg);
        checkData(rowName[rowIdx], rowData[rowIdx], commitData);
        rowIdx++;
      end
      halted = hlt;
    end

    // Fetch froze on the word after the final HLT
    rowIdx = nextCommitRow(rowIdx);
    haltPc = pcOut;
    checkData("pc at halt", dataWidth'(2 * rowWord.size()), haltPc);
    repeat (10) begin
      @(negedge clk);
      if (commitValid) begin
        abortRun("Commit seen after the halt");
      end
      if (!hlt) begin
        abortRun("hlt dropped after the halt");
      end
      checkData("pc frozen after halt", haltPc, pcOut);
    end

    if (rowIdx == rowWord.size()) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abortRun($sformatf("Halted before row %s committed", rowName[rowIdx]));
    end
  end

endmodule

// ==== cpu.f ====
cpuIsaPkg.sv
cpuPipePkg.sv
controlUnit.sv
registerFile.sv
aluCompute.sv
branchResolve.sv
hazardUnit.sv
memory.sv
cpu.sv
cpuTb.sv

// ==== Makefile ====
# Verilator simulation of the pipelined core

SRCS := $(shell cat cpu.f)

all: run

# Rebuilt only when the file list or a source changes
obj_dir/VcpuTb: cpu.f $(SRCS)
	verilator --binary --timing --top-module cpuTb -f cpu.f

# Pass only if the log holds the pass line
run: obj_dir/VcpuTb
	./obj_dir/VcpuTb | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
